//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= renkon.f
TOP       ?= renkon_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/renkon_properties.sv
`timescale 1ns/100ps

module renkon_properties (
  input logic                            clk,
  input logic                            xrst,
  input logic                            pixel_valid,
  input logic                            flush_state,
  input logic                            window_valid,
  input logic                            conv_valid,
  input logic                            frame_done,
  input logic                            buf_we,
  input logic [renkon_pkg::BUFLINE-1:0]  line_we
);

  // The input has no back-pressure, so the source stays quiet during the sweep.
  a_no_pixel_in_flush: assert property (@(posedge clk) disable iff (!xrst)
    flush_state |-> !pixel_valid)
    else $error("pixel_valid arrived during the flush sweep");

  a_conv_follows_window: assert property (@(posedge clk) disable iff (!xrst)
    window_valid |=> conv_valid)
    else $error("conv_valid missing one cycle after window_valid");

  a_conv_has_window: assert property (@(posedge clk) disable iff (!xrst)
    conv_valid |-> $past(window_valid))
    else $error("conv_valid without window_valid one cycle before");

  // A write picks exactly one of the four lines, no write picks none.
  a_one_line_written: assert property (@(posedge clk) disable iff (!xrst)
    buf_we ? $onehot(line_we) : (line_we == '0))
    else $error("line memory write enables not one-hot");

  a_done_apart_from_sum: assert property (@(posedge clk) disable iff (!xrst)
    !(frame_done && conv_valid))
    else $error("frame_done and conv_valid high together");

endmodule

bind renkon_top renkon_properties u_properties (
  .clk          (clk),
  .xrst         (xrst),
  .pixel_valid  (pixel_valid),
  .flush_state  (u_ctrl.state == renkon_pkg::FLUSH),
  .window_valid (window_valid),
  .conv_valid   (conv_valid),
  .frame_done   (frame_done),
  .buf_we       (buf_we),
  .line_we      (u_linebuf.mem_we)
);

//--- bench/renkon_tb.sv
`timescale 1ns/100ps

module renkon_tb;

  localparam int SEED        = 80441;
  localparam int NFRAMES     = 5;
  localparam int OUTW        = renkon_pkg::MAXIMG - renkon_pkg::MAXFIL + 1;  // Sums per output row.
  localparam int NSUMS       = OUTW * OUTW;
  localparam int CYCLE_LIMIT = NFRAMES * (64 * 3 + 8 + 16);

  localparam logic [1:0] PIX_RANDOM = 2'd0;
  localparam logic [1:0] PIX_RAMP   = 2'd1;
  localparam logic [1:0] PIX_LOW    = 2'd2;
  localparam logic [1:0] PIX_HIGH   = 2'd3;

  localparam renkon_pkg::pixel_t P_MIN = 16'sh8000;
  localparam renkon_pkg::pixel_t P_MAX = 16'sh7fff;

  // Weight k of a set is w_base + k * w_step.
  typedef struct packed {
    logic [1:0]         kind;
    logic               gaps;
    renkon_pkg::pixel_t w_base;
    renkon_pkg::pixel_t w_step;
  } stim_t;

  logic                 clk;
  logic                 xrst;
  logic                 pixel_valid;
  renkon_pkg::pixel_t   pixel_data;
  renkon_pkg::weights_t weights;
  logic                 conv_valid;
  renkon_pkg::sum_t     conv_sum;
  logic                 frame_done;

  stim_t              stim_table [NFRAMES];
  renkon_pkg::pixel_t img [renkon_pkg::MAXIMG][renkon_pkg::MAXIMG];
  longint             exp_q [$];  // Expected sums in raster order.
  int                 frames_done = 0;
  int                 sums_seen = 0;
  int                 cycles = 0;

  renkon_top u_dut (
    .clk         (clk),
    .xrst        (xrst),
    .pixel_valid (pixel_valid),
    .pixel_data  (pixel_data),
    .weights     (weights),
    .conv_valid  (conv_valid),
    .conv_sum    (conv_sum),
    .frame_done  (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input longint actual, input longint expected);
    if (actual != expected) begin
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  function automatic renkon_pkg::weights_t make_weights(input renkon_pkg::pixel_t base,
                                                        input renkon_pkg::pixel_t step);
    renkon_pkg::weights_t wt;
    for (int k = 0; k < renkon_pkg::NTAP; k++) begin
      wt.w[k] = renkon_pkg::pixel_t'(int'(base) + int'(step) * k);
    end
    return wt;
  endfunction

  function automatic renkon_pkg::pixel_t make_pixel(input logic [1:0] kind, input int r,
                                                    input int c);
    case (kind)
      PIX_RAMP: return renkon_pkg::pixel_t'((r * renkon_pkg::MAXIMG + c) * 97 - 3000);
      PIX_LOW:  return P_MIN;
      PIX_HIGH: return P_MAX;
      default:  return renkon_pkg::pixel_t'($urandom);
    endcase
  endfunction

  // Valid-mode sum with the window's top left corner at image row i, column j.
  function automatic longint window_sum(input int i, input int j, input renkon_pkg::weights_t wt);
    longint acc;
    acc = 0;
    for (int a = 0; a < renkon_pkg::MAXFIL; a++) begin
      for (int b = 0; b < renkon_pkg::MAXFIL; b++) begin
        acc += longint'(img[i + a][j + b]) * longint'(wt.w[a * renkon_pkg::MAXFIL + b]);
      end
    end
    return acc;
  endfunction

  task automatic drive_frame(input stim_t s);
    renkon_pkg::weights_t wt;
    longint               sums [NSUMS];
    int                   gap;
    wt = make_weights(s.w_base, s.w_step);
    for (int r = 0; r < renkon_pkg::MAXIMG; r++) begin
      for (int c = 0; c < renkon_pkg::MAXIMG; c++) begin
        img[r][c] = make_pixel(s.kind, r, c);
      end
    end
    for (int n = 0; n < NSUMS; n++) begin
      sums[n] = window_sum(n / OUTW, n % OUTW, wt);
    end
    @(posedge clk);
    weights <= wt;
    for (int r = 0; r < renkon_pkg::MAXIMG; r++) begin
      for (int c = 0; c < renkon_pkg::MAXIMG; c++) begin
        gap = s.gaps ? int'($urandom % 3) : 0;
        repeat (gap) begin
          @(posedge clk);
          pixel_valid <= 1'b0;
        end
        @(posedge clk);
        pixel_valid <= 1'b1;
        pixel_data  <= img[r][c];
        if (r >= renkon_pkg::MAXFIL && c >= renkon_pkg::MAXFIL - 1) begin
          exp_q.push_back(sums[(r - renkon_pkg::MAXFIL) * OUTW + c - (renkon_pkg::MAXFIL - 1)]);
        end
      end
    end
    @(posedge clk);
    pixel_valid <= 1'b0;
    for (int j = 0; j < OUTW; j++) begin
      exp_q.push_back(sums[(OUTW - 1) * OUTW + j]);  // Last row comes from the flush sweep.
    end
    while (!frame_done) @(posedge clk);
  endtask

  // Outputs are sampled at the rising edge, before the DUT updates them.
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the run took more than %0d clock cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $fatal(1);
    end else if (xrst) begin
      if (frame_done) begin
        frames_done++;
      end
      if (conv_valid && exp_q.size() == 0) begin
        $display("conv_valid came at %0t while no sum was expected", $time);
        $display("=== FAIL ===");
        $fatal(1);
      end else if (conv_valid) begin
        check("conv_sum", longint'(conv_sum), exp_q.pop_front());
        sums_seen++;
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    stim_table[0] = '{PIX_RANDOM, 1'b0, 16'sd3, -16'sd2};
    stim_table[1] = '{PIX_RAMP, 1'b1, -16'sd4, 16'sd1};
    stim_table[2] = '{PIX_LOW, 1'b0, P_MIN, 16'sd0};   // Largest positive sum.
    stim_table[3] = '{PIX_HIGH, 1'b1, P_MIN, 16'sd0};  // Most negative sum.
    stim_table[4] = '{PIX_RANDOM, 1'b1, P_MAX, -16'sd8191};
    xrst        = 1'b0;
    pixel_valid = 1'b0;
    pixel_data  = '0;
    weights     = '0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
    repeat (2) @(posedge clk);
    check("conv_valid", longint'(conv_valid), 0);
    check("frame_done", longint'(frame_done), 0);
    for (int f = 0; f < NFRAMES; f++) begin
      drive_frame(stim_table[f]);
      repeat (2) @(negedge clk);
      check("frame_done count", longint'(frames_done), longint'(f + 1));
      check("conv_valid count", longint'(sums_seen), longint'(NSUMS * (f + 1)));
    end
    check("pending sums", longint'(exp_q.size()), 0);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- design/mem_sp.sv
`timescale 1ns/100ps

module mem_sp (
  input  logic               clk,
  input  logic               xrst,
  input  logic               mem_we,
  input  renkon_pkg::addr_t  mem_addr,
  input  renkon_pkg::pixel_t mem_wdata,
  output renkon_pkg::pixel_t mem_rdata
);

  renkon_pkg::pixel_t mem [renkon_pkg::MAXIMG];  // One image line.

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_rdata <= '0;
    end else begin
      mem_rdata <= mem[mem_addr];  // Old contents when written in the same cycle.
    end
  end

endmodule

//--- design/renkon_conv.sv
`timescale 1ns/100ps

module renkon_conv (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 window_valid,
  input  renkon_pkg::window_t  buf_window,
  input  renkon_pkg::weights_t weights,
  output logic                 conv_valid,
  output renkon_pkg::sum_t     conv_sum
);

  renkon_pkg::sum_t acc;

  // Nine signed products summed in one combinational tree.
  always_comb begin
    renkon_pkg::prod_t prod;
    acc = '0;
    for (int k = 0; k < renkon_pkg::NTAP; k++) begin
      prod = renkon_pkg::pixel_t'(buf_window.tap[k]) * renkon_pkg::pixel_t'(weights.w[k]);
      acc  = acc + renkon_pkg::sum_t'(prod);  // Sign extends the product.
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      conv_valid <= 1'b0;
      conv_sum   <= '0;
    end else begin
      conv_valid <= window_valid;
      if (window_valid) begin
        conv_sum <= acc;  // Holds the last sum between windows.
      end
    end
  end

endmodule

//--- design/renkon_linebuf.sv
`timescale 1ns/100ps

module renkon_linebuf (
  input  logic                  clk,
  input  logic                  xrst,
  input  renkon_pkg::line_sel_t buf_wsel,
  input  renkon_pkg::line_sel_t buf_rsel,
  input  logic                  buf_we,
  input  logic                  buf_shift,
  input  renkon_pkg::addr_t     buf_addr,
  input  renkon_pkg::pixel_t    buf_input,
  output renkon_pkg::window_t   buf_window
);

  logic [renkon_pkg::BUFLINE-1:0] mem_we;
  renkon_pkg::pixel_t             mem_rdata [renkon_pkg::BUFLINE];
  renkon_pkg::pixel_t             col_in [renkon_pkg::MAXFIL];

  // One memory per line, all sharing the address and the write data.
  for (genvar i = 0; i < renkon_pkg::BUFLINE; i++) begin : g_line
    assign mem_we[i] = buf_we && (buf_wsel == renkon_pkg::line_sel_t'(i + 1));

    mem_sp u_mem (
      .clk       (clk),
      .xrst      (xrst),
      .mem_we    (mem_we[i]),
      .mem_addr  (buf_addr),
      .mem_wdata (buf_input),
      .mem_rdata (mem_rdata[i])
    );
  end

  // Window row i takes line (start + i) mod BUFLINE.
  always_comb begin
    renkon_pkg::line_idx_t line;
    for (int i = 0; i < renkon_pkg::MAXFIL; i++) begin
      line = renkon_pkg::line_idx_t'((i + int'(buf_rsel) + renkon_pkg::BUFLINE - 1)
                                     % renkon_pkg::BUFLINE);
      if (buf_rsel == '0) begin
        col_in[i] = '0;  // No read this cycle.
      end else begin
        col_in[i] = mem_rdata[line];
      end
    end
  end

  // New column enters at the right, older columns move left.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_window <= '0;
    end else if (buf_shift) begin
      for (int i = 0; i < renkon_pkg::MAXFIL; i++) begin
        for (int j = 0; j < renkon_pkg::MAXFIL - 1; j++) begin
          buf_window.tap[renkon_pkg::MAXFIL * i + j] <=
            buf_window.tap[renkon_pkg::MAXFIL * i + j + 1];
        end
        buf_window.tap[renkon_pkg::MAXFIL * i + renkon_pkg::MAXFIL - 1] <= col_in[i];
      end
    end
  end

endmodule

//--- design/renkon_linebuf_ctrl.sv
`timescale 1ns/100ps

module renkon_linebuf_ctrl (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  pixel_valid,
  input  renkon_pkg::pixel_t    pixel_data,
  output logic                  buf_we,
  output logic                  buf_shift,
  output renkon_pkg::line_sel_t buf_wsel,
  output renkon_pkg::line_sel_t buf_rsel,
  output renkon_pkg::addr_t     buf_addr,
  output renkon_pkg::pixel_t    buf_input,
  output logic                  window_valid,
  output logic                  frame_done
);

  renkon_pkg::ctrl_state_t state;
  renkon_pkg::row_t        row;
  renkon_pkg::addr_t       col;
  renkon_pkg::line_sel_t   rd_sel;      // Read select of the step, one cycle ahead of buf_rsel.
  logic [1:0]              win_pipe;
  logic [3:0]              last_pipe;   // Last flush step on its way to frame_done.
  logic                    wr_step;
  logic                    rd_step;
  logic                    col_last;

  assign wr_step  = pixel_valid && (state != renkon_pkg::FLUSH);
  assign rd_step  = (state == renkon_pkg::STREAM && pixel_valid) || state == renkon_pkg::FLUSH;
  assign col_last = col == renkon_pkg::addr_t'(renkon_pkg::MAXIMG - 1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= renkon_pkg::IDLE;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        renkon_pkg::IDLE:
          if (pixel_valid) state <= renkon_pkg::FILL;
        renkon_pkg::FILL:
          if (pixel_valid && col_last && row == renkon_pkg::row_t'(renkon_pkg::MAXFIL - 1))
            state <= renkon_pkg::STREAM;
        renkon_pkg::STREAM:
          if (pixel_valid && col_last && row == renkon_pkg::row_t'(renkon_pkg::MAXIMG - 1))
            state <= renkon_pkg::FLUSH;
        default:
          if (col_last) state <= renkon_pkg::IDLE;
      endcase
      if (wr_step || rd_step) begin
        col <= col_last ? '0 : col + 1'b1;
      end
      if (wr_step && col_last) begin
        row <= row + 1'b1;  // Wraps to 0 at the frame end, the flush keeps it there.
      end
    end
  end

  // Write and read of the shared address, one cycle after the step.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_we    <= 1'b0;
      buf_wsel  <= '0;
      buf_addr  <= '0;
      rd_sel    <= '0;
      win_pipe  <= '0;
      last_pipe <= '0;
    end else begin
      buf_we   <= wr_step;
      buf_wsel <= wr_step ? renkon_pkg::line_sel_t'(row % renkon_pkg::BUFLINE + 1) : '0;
      if (wr_step || rd_step) begin
        buf_addr <= col;
      end
      // Window starts MAXFIL rows above the row being written.
      rd_sel <= rd_step ? renkon_pkg::line_sel_t'((row + renkon_pkg::BUFLINE - renkon_pkg::MAXFIL)
                                                  % renkon_pkg::BUFLINE + 1) : '0;
      win_pipe  <= {win_pipe[0], rd_step && col >= renkon_pkg::addr_t'(renkon_pkg::MAXFIL - 1)};
      last_pipe <= {last_pipe[2:0], state == renkon_pkg::FLUSH && col_last};
    end
  end

  always_ff @(posedge clk) begin
    buf_input <= pixel_data;
  end

  // Shift follows the read by one cycle to cover the memory latency.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_shift    <= 1'b0;
      buf_rsel     <= '0;
      window_valid <= 1'b0;
      frame_done   <= 1'b0;
    end else begin
      buf_shift    <= rd_sel != '0;
      buf_rsel     <= rd_sel;
      window_valid <= win_pipe[1];
      frame_done   <= last_pipe[3];  // One cycle after the last sum.
    end
  end

endmodule

//--- design/renkon_pkg.sv
package renkon_pkg;

  localparam int MAXFIL    = 3;            // Filter edge, also the window rows and columns.
  localparam int MAXIMG    = 8;            // Image width and height.
  localparam int BUFLINE   = MAXFIL + 1;   // One line more than the window is tall.
  localparam int NTAP      = MAXFIL * MAXFIL;
  localparam int DWIDTH    = 16;
  localparam int PWIDTH    = 2 * DWIDTH;   // Full product of two pixels.
  localparam int SWIDTH    = 36;           // Nine products plus growth.
  localparam int ADDRWIDTH = 3;
  localparam int SELWIDTH  = 3;
  localparam int LINEWIDTH = 2;

  typedef logic signed [DWIDTH-1:0] pixel_t;
  typedef logic signed [PWIDTH-1:0] prod_t;
  typedef logic signed [SWIDTH-1:0] sum_t;

  typedef logic [ADDRWIDTH-1:0] addr_t;    // Column address inside one line.
  typedef logic [ADDRWIDTH-1:0] row_t;     // Image row counter.
  typedef logic [LINEWIDTH-1:0] line_idx_t;

  // Write select 0 is no write; 1 to 4 pick lines 0 to 3.
  // Read select 0 is a zero window; k+1 starts the window at line k.
  typedef logic [SELWIDTH-1:0] line_sel_t;

  // Row-major, so w[0] is the top left weight.
  typedef struct packed {
    pixel_t [0:NTAP-1] w;
  } weights_t;

  // Oldest row first, leftmost column first.
  typedef struct packed {
    pixel_t [0:NTAP-1] tap;
  } window_t;

  typedef enum logic [1:0] {
    IDLE,    // Waiting for the first pixel of a frame.
    FILL,    // Rows 0 to 2, writes only.
    STREAM,  // Rows 3 to 7, writes and window reads.
    FLUSH    // Read sweep for the last output row.
  } ctrl_state_t;

endpackage

//--- design/renkon_top.sv
`timescale 1ns/100ps

module renkon_top (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 pixel_valid,
  input  renkon_pkg::pixel_t   pixel_data,
  input  renkon_pkg::weights_t weights,
  output logic                 conv_valid,
  output renkon_pkg::sum_t     conv_sum,
  output logic                 frame_done
);

  logic                  buf_we;
  logic                  buf_shift;
  renkon_pkg::line_sel_t buf_wsel;
  renkon_pkg::line_sel_t buf_rsel;
  renkon_pkg::addr_t     buf_addr;
  renkon_pkg::pixel_t    buf_input;
  renkon_pkg::window_t   buf_window;
  logic                  window_valid;

  renkon_linebuf_ctrl u_ctrl (
    .clk          (clk),
    .xrst         (xrst),
    .pixel_valid  (pixel_valid),
    .pixel_data   (pixel_data),
    .buf_we       (buf_we),
    .buf_shift    (buf_shift),
    .buf_wsel     (buf_wsel),
    .buf_rsel     (buf_rsel),
    .buf_addr     (buf_addr),
    .buf_input    (buf_input),
    .window_valid (window_valid),
    .frame_done   (frame_done)
  );

  renkon_linebuf u_linebuf (
    .clk        (clk),
    .xrst       (xrst),
    .buf_wsel   (buf_wsel),
    .buf_rsel   (buf_rsel),
    .buf_we     (buf_we),
    .buf_shift  (buf_shift),
    .buf_addr   (buf_addr),
    .buf_input  (buf_input),
    .buf_window (buf_window)
  );

  renkon_conv u_conv (
    .clk          (clk),
    .xrst         (xrst),
    .window_valid (window_valid),
    .buf_window   (buf_window),
    .weights      (weights),
    .conv_valid   (conv_valid),
    .conv_sum     (conv_sum)
  );

endmodule

//--- renkon.f
design/renkon_pkg.sv
design/mem_sp.sv
design/renkon_linebuf.sv
design/renkon_linebuf_ctrl.sv
design/renkon_conv.sv
design/renkon_top.sv
bench/renkon_properties.sv
bench/renkon_tb.sv
